//--- all.f
+incdir+bench
design/mem_cfg_pkg.sv
design/mem_access_pkg.sv
design/row_map_table.sv
design/dual_copy_bank.sv
design/spare_row_cache.sv
design/conflict_ctrl.sv
design/read_return.sv
design/mp_mem_top.sv
bench/tb_mp_mem.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass message.
set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"

verilator --binary --timing --assert -f all.f --top-module tb_mp_mem \
  --Mdir obj_dir -o tb_mp_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mp_mem > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
  echo "Simulation run returned status ${sim_status}"
  exit 1
fi

if grep -q "Simulation passed" "${log_file}"; then
  exit 0
fi
echo "Pass message not found in ${log_file}"
exit 1

//--- bench/tb_stimulus.svh
// Columns: port 0 op, addr, din, expected read data, then the same four for port 1
typedef struct packed {
  logic [1:0] op0;
  addr_t      addr0;
  data_t      din0;
  data_t      exp0;
  logic [1:0] op1;
  addr_t      addr1;
  data_t      din1;
  data_t      exp1;
} stim_row_t;

localparam int num_rows = 16;

stim_row_t stim_table [num_rows];

task automatic load_table();
  // Plain write then read back on both ports and both copies
  stim_table[0]  = '{op_write, 6'h05, 16'h1111, 16'h0000, op_write, 6'h0a, 16'h2222, 16'h0000};
  stim_table[1]  = '{op_read,  6'h05, 16'h0000, 16'h1111, op_read,  6'h0a, 16'h0000, 16'h2222};
  stim_table[2]  = '{op_read,  6'h0a, 16'h0000, 16'h2222, op_read,  6'h05, 16'h0000, 16'h1111};
  // Two writes to bank 0, then a bank 1 write into cache row 7 evicts the bank 0 word
  stim_table[3]  = '{op_write, 6'h0c, 16'h3333, 16'h0000, op_write, 6'h1c, 16'h7777, 16'h0000};
  stim_table[4]  = '{op_write, 6'h05, 16'h5555, 16'h0000, op_write, 6'h1d, 16'h7d7d, 16'h0000};
  stim_table[5]  = '{op_read,  6'h0c, 16'h0000, 16'h3333, op_read,  6'h1c, 16'h0000, 16'h7777};
  stim_table[6]  = '{op_read,  6'h1d, 16'h0000, 16'h7d7d, op_read,  6'h05, 16'h0000, 16'h5555};
  stim_table[7]  = '{op_read,  6'h1c, 16'h0000, 16'h7777, op_read,  6'h1d, 16'h0000, 16'h7d7d};
  // Read meets write in one bank, the read sees the old word
  stim_table[8]  = '{op_read,  6'h0c, 16'h0000, 16'h3333, op_write, 6'h0c, 16'h3c3c, 16'h0000};
  stim_table[9]  = '{op_write, 6'h20, 16'h8888, 16'h0000, op_read,  6'h1c, 16'h0000, 16'h7777};
  stim_table[10] = '{op_read,  6'h0c, 16'h0000, 16'h3c3c, op_read,  6'h20, 16'h0000, 16'h8888};
  // A bank write drops the cached copy of the same word
  stim_table[11] = '{op_write, 6'h0c, 16'h4c4c, 16'h0000, op_idle,  6'h00, 16'h0000, 16'h0000};
  stim_table[12] = '{op_idle,  6'h00, 16'h0000, 16'h0000, op_read,  6'h0c, 16'h0000, 16'h4c4c};
  // Both ports write one address, port 1 wins
  stim_table[13] = '{op_write, 6'h2a, 16'haaaa, 16'h0000, op_write, 6'h2a, 16'hbbbb, 16'h0000};
  stim_table[14] = '{op_read,  6'h2a, 16'h0000, 16'hbbbb, op_read,  6'h2a, 16'h0000, 16'hbbbb};
  stim_table[15] = '{op_idle,  6'h00, 16'h0000, 16'h0000, op_idle,  6'h00, 16'h0000, 16'h0000};
endtask

task automatic run_table();
  stim_row_t row;
  for (int i = 0; i < num_rows; i++) begin
    row = stim_table[i];
    run_cycle(make_req(row.op0, row.addr0, row.din0), make_req(row.op1, row.addr1, row.din1),
              row.exp0, row.exp1, 1'b0, $sformatf("table row %0d", i));
  end
endtask

//--- bench/tb_mp_mem.sv
`timescale 1ns/1ps

module tb_mp_mem;

  import mem_cfg_pkg::*;
  import mem_access_pkg::*;

  localparam logic [1:0] op_idle  = 2'd0;
  localparam logic [1:0] op_read  = 2'd1;  // Code 3 also reads
  localparam logic [1:0] op_write = 2'd2;

  localparam int reset_cycles   = 16;
  localparam int preload_cycles = num_addr / num_ports;
  localparam int random_cycles  = 400;

  logic                 clk = 1'b0;
  logic                 arst_n;
  port_req_t            req0;
  port_req_t            req1;
  logic                 ready;
  logic [num_ports-1:0] rd_vld;
  data_t                rd_dout0;
  data_t                rd_dout1;

  data_t       model     [num_addr];
  logic [15:0] lfsr_state;
  logic        pend_vld  [num_ports];  // Read issued last cycle and due now
  data_t       pend_exp  [num_ports];
  string       pend_name [num_ports];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  `include "tb_stimulus.svh"

  localparam int max_cycles = reset_cycles + num_vrow + num_rows + preload_cycles
                              + random_cycles + 64;

  always #10 clk = ~clk;

  mp_mem_top u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .req0     (req0),
    .req1     (req1),
    .ready    (ready),
    .rd_vld   (rd_vld),
    .rd_dout0 (rd_dout0),
    .rd_dout1 (rd_dout1)
  );

  // ################################################
  // Helpers
  // ################################################

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[14:0], lfsr_state[15]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic port_req_t make_req(input logic [1:0] op, input addr_t addr, input data_t din);
    port_req_t r;
    r.read  = op[0];
    r.write = (op == op_write);
    r.addr  = addr;
    r.din   = din;
    return r;
  endfunction

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_returns();
    for (int p = 0; p < num_ports; p++) begin
      check_value({pend_name[p], " rd_vld"}, data_t'(pend_vld[p]), data_t'(rd_vld[p]));
      if (pend_vld[p]) begin
        check_value({pend_name[p], " data"}, pend_exp[p], (p == 0) ? rd_dout0 : rd_dout1);
      end
    end
  endtask

  // Checks the previous cycle's reads, then drives the next requests
  task automatic run_cycle(input port_req_t r0, input port_req_t r1, input data_t exp0,
                           input data_t exp1, input logic use_model, input string name);
    port_req_t r   [num_ports];
    data_t     exp [num_ports];
    @(negedge clk);
    check_returns();
    r[0]   = r0;
    r[1]   = r1;
    exp[0] = exp0;
    exp[1] = exp1;
    req0   = r0;
    req1   = r1;
    for (int p = 0; p < num_ports; p++) begin
      pend_vld[p]  = r[p].read;
      pend_exp[p]  = use_model ? model[r[p].addr] : exp[p];  // Reads see the old word
      pend_name[p] = $sformatf("%s port %0d", name, p);
    end
    for (int p = 0; p < num_ports; p++) begin
      if (r[p].write) begin
        model[r[p].addr] = r[p].din;  // Port 1 applied last
      end
    end
  endtask

  task automatic random_req(output port_req_t r);
    logic [15:0] op;
    logic [15:0] adr;
    logic [15:0] dat;
    take_bits(2, op);
    take_bits(bit_addr, adr);
    take_bits(data_width, dat);
    r = make_req(op[1:0], addr_t'(adr), data_t'(dat));
  endtask

  // ################################################
  // Timeout
  // ################################################

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run went past %0d cycles without finishing", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ################################################
  // Test sequence
  // ################################################

  initial begin
    logic [15:0] d0;
    logic [15:0] d1;
    port_req_t   r0;
    port_req_t   r1;
    arst_n     = 1'b0;
    req0       = make_req(op_write, 6'h05, 16'hdead);  // Conflicting requests that must be ignored
    req1       = make_req(op_read, 6'h05, 16'h0000);
    lfsr_state = 16'd83;
    for (int p = 0; p < num_ports; p++) begin
      pend_vld[p]  = 1'b0;
      pend_exp[p]  = '0;
      pend_name[p] = "init";
    end
    repeat (reset_cycles) begin
      @(negedge clk);
      check_value("reset ready", '0, data_t'(ready));
      check_value("reset rd_vld", '0, data_t'(rd_vld));
    end
    arst_n = 1'b1;
    for (int i = 1; i <= num_vrow; i++) begin
      @(negedge clk);
      check_value($sformatf("init sweep cycle %0d ready", i), data_t'(i == num_vrow),
                  data_t'(ready));
      check_value($sformatf("init sweep cycle %0d rd_vld", i), '0, data_t'(rd_vld));
    end
    req0 = '0;
    req1 = '0;
    load_table();
    run_table();
    for (int i = 0; i < preload_cycles; i++) begin
      take_bits(data_width, d0);
      take_bits(data_width, d1);
      run_cycle(make_req(op_write, addr_t'(2 * i), d0), make_req(op_write, addr_t'(2 * i + 1), d1),
                '0, '0, 1'b1, $sformatf("preload %0d", i));
    end
    for (int i = 0; i < random_cycles; i++) begin
      random_req(r0);
      random_req(r1);
      run_cycle(r0, r1, '0, '0, 1'b1, $sformatf("random cycle %0d", i));
    end
    run_cycle('0, '0, '0, '0, 1'b0, "flush");
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- design/mp_mem_top.sv
`timescale 1ns/1ps

module mp_mem_top (
  input  logic                              clk,
  input  logic                              arst_n,
  input  mem_access_pkg::port_req_t         req0,
  input  mem_access_pkg::port_req_t         req1,
  output logic                              ready,
  output logic [mem_cfg_pkg::num_ports-1:0] rd_vld,
  output mem_cfg_pkg::data_t                rd_dout0,
  output mem_cfg_pkg::data_t                rd_dout1
);

  import mem_cfg_pkg::*;
  import mem_access_pkg::*;

  vrow_t      row0;
  vrow_t      row1;
  vrow_t      row_w;
  map_entry_t map_rd0;
  map_entry_t map_rd1;
  map_entry_t map_rd_w;
  map_upd_t   upd0;
  map_upd_t   upd1;
  data_t      cache_rd0;
  data_t      cache_rd1;
  data_t      cache_rd_w;
  logic       cache_we;
  vrow_t      cache_row;
  data_t      cache_din;
  bank_cmd_t  bank_cmd [num_vbnk];
  rd_src_t    rd_src0;
  rd_src_t    rd_src1;
  data_t      dout_b [num_vbnk];
  data_t      dout_c [num_vbnk];

  // ################################################
  // Control and lookup structures
  // ################################################

  row_map_table u_map (
    .clk, .arst_n, .row0, .row1, .row_w,
    .map_rd0, .map_rd1, .map_rd_w, .upd0, .upd1, .ready
  );

  spare_row_cache u_cache (
    .clk, .we(cache_we), .wr_row(cache_row), .din(cache_din),
    .row0, .row1, .row_w,
    .dout0(cache_rd0), .dout1(cache_rd1), .dout_w(cache_rd_w)
  );

  conflict_ctrl u_ctrl (
    .req0, .req1, .ready, .map_rd0, .map_rd1, .map_rd_w,
    .cache_rd_w, .cache_rd0, .cache_rd1, .row0, .row1, .row_w, .upd0, .upd1,
    .cache_we, .cache_row, .cache_din, .bank_cmd, .rd_src0, .rd_src1
  );

  // ################################################
  // Banks and read return
  // ################################################

  for (genvar b = 0; b < num_vbnk; b++) begin : g_bank
    dual_copy_bank u_bank (
      .clk,
      .cmd(bank_cmd[b]),
      .dout_b(dout_b[b]),
      .dout_c(dout_c[b])
    );
  end

  read_return u_ret (
    .clk, .arst_n, .rd_src0, .rd_src1, .dout_b, .dout_c,
    .rd_vld, .rd_dout0, .rd_dout1
  );

endmodule

//--- design/read_return.sv
`timescale 1ns/1ps

module read_return (
  input  logic                                clk,
  input  logic                                arst_n,
  input  mem_access_pkg::rd_src_t             rd_src0,
  input  mem_access_pkg::rd_src_t             rd_src1,
  input  mem_cfg_pkg::data_t                  dout_b [mem_cfg_pkg::num_vbnk],
  input  mem_cfg_pkg::data_t                  dout_c [mem_cfg_pkg::num_vbnk],
  output logic [mem_cfg_pkg::num_ports-1:0]   rd_vld,
  output mem_cfg_pkg::data_t                  rd_dout0,
  output mem_cfg_pkg::data_t                  rd_dout1
);

  import mem_cfg_pkg::*;
  import mem_access_pkg::*;

  rd_src_t src_in  [num_ports];
  route_e  src_q   [num_ports];
  vbnk_t   bank_q  [num_ports];
  data_t   cache_q [num_ports];
  data_t   dout    [num_ports];

  assign src_in[0] = rd_src0;
  assign src_in[1] = rd_src1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int p = 0; p < num_ports; p++) begin
        src_q[p] <= route_idle;
      end
    end else begin
      for (int p = 0; p < num_ports; p++) begin
        src_q[p] <= src_in[p].src;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < num_ports; p++) begin
      bank_q[p]  <= src_in[p].bank;
      cache_q[p] <= src_in[p].cache_data;  // Sampled before the cache write lands
    end
  end

  // Port 0 owns copy B, port 1 owns copy C
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      if (src_q[p] == route_cache) begin
        dout[p] = cache_q[p];
      end else begin
        dout[p] = (p == 0) ? dout_b[bank_q[p]] : dout_c[bank_q[p]];
      end
      rd_vld[p] = (src_q[p] != route_idle);
    end
  end

  assign rd_dout0 = dout[0];
  assign rd_dout1 = dout[1];

endmodule

//--- design/conflict_ctrl.sv
`timescale 1ns/1ps

module conflict_ctrl (
  input  mem_access_pkg::port_req_t  req0,
  input  mem_access_pkg::port_req_t  req1,
  input  logic                       ready,
  input  mem_access_pkg::map_entry_t map_rd0,
  input  mem_access_pkg::map_entry_t map_rd1,
  input  mem_access_pkg::map_entry_t map_rd_w,
  input  mem_cfg_pkg::data_t         cache_rd_w,
  input  mem_cfg_pkg::data_t         cache_rd0,
  input  mem_cfg_pkg::data_t         cache_rd1,
  output mem_cfg_pkg::vrow_t         row0,
  output mem_cfg_pkg::vrow_t         row1,
  output mem_cfg_pkg::vrow_t         row_w,
  output mem_access_pkg::map_upd_t   upd0,
  output mem_access_pkg::map_upd_t   upd1,
  output logic                       cache_we,
  output mem_cfg_pkg::vrow_t         cache_row,
  output mem_cfg_pkg::data_t         cache_din,
  output mem_access_pkg::bank_cmd_t  bank_cmd [mem_cfg_pkg::num_vbnk],
  output mem_access_pkg::rd_src_t    rd_src0,
  output mem_access_pkg::rd_src_t    rd_src1
);

  import mem_cfg_pkg::*;
  import mem_access_pkg::*;

  port_req_t            req      [num_ports];
  map_entry_t           map_rd   [num_ports];
  data_t                cache_rd [num_ports];
  rd_src_t              rd_src   [num_ports];
  vbnk_t                pbnk     [num_ports];
  vrow_t                prow     [num_ports];
  logic [num_ports-1:0] wr;
  logic [num_ports-1:0] rd;
  logic [num_ports-1:0] hit;
  logic [num_ports-1:0] div;
  logic [num_ports-1:0] bwr;
  logic [num_ports-1:0] inval;
  logic                 conflict;
  logic                 divert;
  logic                 evict;
  vbnk_t                div_bnk;

  assign req[0]      = req0;
  assign req[1]      = req1;
  assign map_rd[0]   = map_rd0;
  assign map_rd[1]   = map_rd1;
  assign cache_rd[0] = cache_rd0;
  assign cache_rd[1] = cache_rd1;

  // ################################################
  // Port decode and map lookup
  // ################################################

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      pbnk[p] = req[p].addr[bit_vbnk-1:0];
      prow[p] = req[p].addr[bit_addr-1:bit_vbnk];
      wr[p]   = ready & req[p].write;
      rd[p]   = ready & req[p].read & ~req[p].write;
      hit[p]  = map_rd[p].valid & (map_rd[p].bank == pbnk[p]);  // Word lives in the cache
    end
  end

  // ################################################
  // Conflict, diversion and eviction
  // ################################################

  assign conflict = (wr[0] | rd[0]) & (wr[1] | rd[1]) & (pbnk[0] == pbnk[1]) & (|wr);
  assign div      = {conflict & wr[1], conflict & wr[0] & ~wr[1]};  // Port 1 yields on two writes
  assign divert   = |div;
  assign bwr      = wr & ~div;
  assign inval    = bwr & hit;

  assign row0    = prow[0];
  assign row1    = prow[1];
  assign row_w   = div[1] ? prow[1] : prow[0];
  assign div_bnk = div[1] ? pbnk[1] : pbnk[0];
  assign evict   = divert & map_rd_w.valid & (map_rd_w.bank != div_bnk);

  assign cache_we  = divert;
  assign cache_row = row_w;
  assign cache_din = div[1] ? req1.din : req0.din;

  always_comb begin
    upd0.en    = inval[0];
    upd0.row   = prow[0];
    upd0.entry = '0;
    if (divert) begin
      upd1.en          = 1'b1;
      upd1.row         = row_w;
      upd1.entry.valid = 1'b1;
      upd1.entry.bank  = div_bnk;
    end else begin
      upd1.en    = inval[1];
      upd1.row   = prow[1];
      upd1.entry = '0;
    end
  end

  // ################################################
  // Read sources and bank commands
  // ################################################

  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      rd_src[p].src        = !rd[p] ? route_idle : (hit[p] ? route_cache : route_bank);
      rd_src[p].bank       = pbnk[p];
      rd_src[p].cache_data = cache_rd[p];
    end
  end

  assign rd_src0 = rd_src[0];
  assign rd_src1 = rd_src[1];

  always_comb begin
    logic [2:0] wsrc;
    for (int b = 0; b < num_vbnk; b++) begin
      wsrc[0] = bwr[0] & (pbnk[0] == vbnk_t'(b));
      wsrc[1] = bwr[1] & (pbnk[1] == vbnk_t'(b));
      wsrc[2] = evict & (map_rd_w.bank == vbnk_t'(b));  // Victim goes home to an idle bank
      bank_cmd[b]        = '0;
      bank_cmd[b].read_b = rd[0] & ~hit[0] & (pbnk[0] == vbnk_t'(b));
      bank_cmd[b].read_c = rd[1] & ~hit[1] & (pbnk[1] == vbnk_t'(b));
      bank_cmd[b].row[0] = prow[0];
      bank_cmd[b].row[1] = prow[1];
      bank_cmd[b].write  = |wsrc;
      if (wsrc[0]) begin
        bank_cmd[b].row = {prow[0], prow[0]};
        bank_cmd[b].din = req0.din;
      end else if (wsrc[1]) begin
        bank_cmd[b].row = {prow[1], prow[1]};
        bank_cmd[b].din = req1.din;
      end else if (wsrc[2]) begin
        bank_cmd[b].row = {row_w, row_w};
        bank_cmd[b].din = cache_rd_w;
      end
      if (ready) begin
        a_one_write: assert ($onehot0(wsrc))
          else $error("bank %0d got more than one write", b);
      end
    end
  end

endmodule

//--- design/spare_row_cache.sv
`timescale 1ns/1ps

module spare_row_cache (
  input  logic               clk,
  input  logic               we,
  input  mem_cfg_pkg::vrow_t wr_row,
  input  mem_cfg_pkg::data_t din,
  input  mem_cfg_pkg::vrow_t row0,
  input  mem_cfg_pkg::vrow_t row1,
  input  mem_cfg_pkg::vrow_t row_w,
  output mem_cfg_pkg::data_t dout0,
  output mem_cfg_pkg::data_t dout1,
  output mem_cfg_pkg::data_t dout_w
);

  import mem_cfg_pkg::*;

  data_t words [num_vrow];  // One spare word per row, any bank

  always_ff @(posedge clk) begin
    if (we) begin
      words[wr_row] <= din;
    end
  end

  // Reads see the contents from before this cycle's write
  assign dout0  = words[row0];
  assign dout1  = words[row1];
  assign dout_w = words[row_w];  // Victim word for an eviction

endmodule

//--- design/dual_copy_bank.sv
`timescale 1ns/1ps

module dual_copy_bank (
  input  logic                      clk,
  input  mem_access_pkg::bank_cmd_t cmd,
  output mem_cfg_pkg::data_t        dout_b,
  output mem_cfg_pkg::data_t        dout_c
);

  import mem_cfg_pkg::*;

  data_t copy_b [num_vrow];
  data_t copy_c [num_vrow];

  // Copy B serves port 0 reads, copy C serves port 1 reads
  always_ff @(posedge clk) begin
    if (cmd.write) begin
      copy_b[cmd.row[0]] <= cmd.din;
      copy_c[cmd.row[1]] <= cmd.din;
    end
    if (cmd.read_b) begin
      dout_b <= copy_b[cmd.row[0]];
    end
    if (cmd.read_c) begin
      dout_c <= copy_c[cmd.row[1]];
    end
  end

  // A write occupies both copies, so no read may share the cycle
  a_write_excl: assert property (
    @(posedge clk) cmd.write |-> !(cmd.read_b || cmd.read_c)
  );

endmodule

//--- design/row_map_table.sv
`timescale 1ns/1ps

module row_map_table (
  input  logic                       clk,
  input  logic                       arst_n,
  input  mem_cfg_pkg::vrow_t         row0,
  input  mem_cfg_pkg::vrow_t         row1,
  input  mem_cfg_pkg::vrow_t         row_w,
  output mem_access_pkg::map_entry_t map_rd0,
  output mem_access_pkg::map_entry_t map_rd1,
  output mem_access_pkg::map_entry_t map_rd_w,
  input  mem_access_pkg::map_upd_t   upd0,
  input  mem_access_pkg::map_upd_t   upd1,
  output logic                       ready
);

  import mem_cfg_pkg::*;
  import mem_access_pkg::*;

  map_entry_t  map [num_vrow];
  init_state_e state;
  vrow_t       clr_row;

  // ################################################
  // Initialization sweep
  // ################################################

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_clear;
      clr_row <= '0;
    end else if (state == st_clear) begin
      clr_row <= clr_row + vrow_t'(1);
      if (clr_row == vrow_t'(num_vrow - 1)) begin
        state <= st_run;  // Last row cleared on this edge
      end
    end
  end

  assign ready = (state == st_run);

  // ################################################
  // Map storage
  // ################################################

  always_ff @(posedge clk) begin
    if (state == st_clear) begin
      map[clr_row] <= '0;
    end else begin
      if (upd0.en) begin
        map[upd0.row] <= upd0.entry;
      end
      if (upd1.en) begin
        map[upd1.row] <= upd1.entry;  // Diverted write owns the row on a tie
      end
    end
  end

  assign map_rd0  = map[row0];
  assign map_rd1  = map[row1];
  assign map_rd_w = map[row_w];

  // The controller must hold off until the sweep is done
  a_no_upd_in_clear: assert property (
    @(posedge clk) disable iff (!arst_n)
    (state == st_clear) |-> !(upd0.en || upd1.en)
  );

endmodule

//--- design/mem_access_pkg.sv
package mem_access_pkg;

  typedef enum logic [1:0] {
    route_idle  = 2'd0,
    route_bank  = 2'd1,
    route_cache = 2'd2
  } route_e;

  typedef enum logic {
    st_clear = 1'b0,
    st_run   = 1'b1
  } init_state_e;

  typedef struct packed {
    logic               read;
    logic               write;
    mem_cfg_pkg::addr_t addr;
    mem_cfg_pkg::data_t din;
  } port_req_t;

  typedef struct packed {
    logic               valid;
    mem_cfg_pkg::vbnk_t bank;  // Home bank of the word held in the cache row
  } map_entry_t;

  typedef struct packed {
    logic               en;
    mem_cfg_pkg::vrow_t row;
    map_entry_t         entry;
  } map_upd_t;

  // Row [0] addresses copy B and row [1] copy C, a write sets both the same
  typedef struct packed {
    logic                     read_b;
    logic                     read_c;
    logic                     write;
    mem_cfg_pkg::vrow_t [1:0] row;
    mem_cfg_pkg::data_t       din;
  } bank_cmd_t;

  typedef struct packed {
    route_e             src;
    mem_cfg_pkg::vbnk_t bank;
    mem_cfg_pkg::data_t cache_data;
  } rd_src_t;

endpackage

//--- design/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // ################################################
  // Geometry
  // ################################################

  localparam int data_width = 16;
  localparam int num_vbnk   = 4;
  localparam int bit_vbnk   = $clog2(num_vbnk);
  localparam int num_vrow   = 16;
  localparam int bit_vrow   = $clog2(num_vrow);
  localparam int num_addr   = num_vbnk * num_vrow;
  localparam int bit_addr   = $clog2(num_addr);
  localparam int num_ports  = 2;

  // ################################################
  // Address and data types
  // ################################################

  typedef logic [data_width-1:0] data_t;
  typedef logic [bit_vbnk-1:0]   vbnk_t;  // Low address bits
  typedef logic [bit_vrow-1:0]   vrow_t;  // High address bits
  typedef logic [bit_addr-1:0]   addr_t;

endpackage
